//--- bus_pkg.sv
`default_nettype none

package bus_pkg;

  ////////////////////////////////////////
  // bus field widths
  ////////////////////////////////////////

  localparam int unsigned ADDR_W = 8;   // byte address, only low bits reach the array
  localparam int unsigned DATA_W = 32;  // one word per beat, no strobes
  localparam int unsigned ID_W   = 4;   // transaction id, echoed on B and R

  // the memory target decodes the low four address bits
  localparam int unsigned MEM_WORDS = 16;

  ////////////////////////////////////////
  // payload types
  ////////////////////////////////////////

  typedef logic [ADDR_W-1:0] addr_t;  // AW and AR address
  typedef logic [DATA_W-1:0] data_t;  // W and R data
  typedef logic [ID_W-1:0]   id_t;    // id on AW, AR, B and R

endpackage : bus_pkg

`default_nettype wire

//--- iso_pkg.sv
`default_nettype none

package iso_pkg;

  // cap on outstanding transactions per direction
  localparam int unsigned MAX_PENDING = 4;

  // one extra bit so the counter can hold MAX_PENDING itself
  localparam int unsigned CNT_W = $clog2(MAX_PENDING) + 1;

  typedef logic [CNT_W-1:0] pend_cnt_t;  // pending and w unlock counts

  // per-direction gate state
  typedef enum logic [1:0] {
    NORMAL,   // pass-through
    HOLD,     // keep a started address valid high until it is taken
    DRAIN,    // block new addresses, wait for responses
    ISOLATE   // everything toward the target is silenced
  } gate_state_t;

endpackage : iso_pkg

`default_nettype wire

//--- bus_isolate.sv
`default_nettype none

module bus_isolate import bus_pkg::*; import iso_pkg::*; (
  input  wire         clk_i,
  input  wire         rst_n_i,
  // slave side, from the bus master
  input  wire         s_aw_valid_i,
  output logic        s_aw_ready_o,
  input  addr_t       s_aw_addr_i,
  input  id_t         s_aw_id_i,
  input  wire         s_w_valid_i,
  output logic        s_w_ready_o,
  input  data_t       s_w_data_i,
  output logic        s_b_valid_o,
  input  wire         s_b_ready_i,
  output id_t         s_b_id_o,
  input  wire         s_ar_valid_i,
  output logic        s_ar_ready_o,
  input  addr_t       s_ar_addr_i,
  input  id_t         s_ar_id_i,
  output logic        s_r_valid_o,
  input  wire         s_r_ready_i,
  output id_t         s_r_id_o,
  output data_t       s_r_data_o,
  // master side, toward the target
  output logic        m_aw_valid_o,
  input  wire         m_aw_ready_i,
  output addr_t       m_aw_addr_o,
  output id_t         m_aw_id_o,
  output logic        m_w_valid_o,
  input  wire         m_w_ready_i,
  output data_t       m_w_data_o,
  input  wire         m_b_valid_i,
  output logic        m_b_ready_o,
  input  id_t         m_b_id_i,
  output logic        m_ar_valid_o,
  input  wire         m_ar_ready_i,
  output addr_t       m_ar_addr_o,
  output id_t         m_ar_id_o,
  input  wire         m_r_valid_i,
  output logic        m_r_ready_o,
  input  id_t         m_r_id_i,
  input  data_t       m_r_data_i,
  // four-phase isolation handshake
  input  wire         iso_req_i,
  output logic        iso_ack_o
);

  gate_state_t wr_state_q, rd_state_q;
  pend_cnt_t   pend_aw_q, pend_ar_q;  // outstanding writes / reads
  pend_cnt_t   w_unlock_q;            // addresses sent whose data beat is still due
  logic        aw_xfer, w_xfer, b_xfer, ar_xfer, r_xfer;
  logic        aw_cap, ar_cap;        // counter limit reached
  logic        w_open;                // data channel unlocked

  // shared next-state rule for both directions
  function automatic gate_state_t next_state(
    input gate_state_t cur,
    input logic        cap,
    input logic        s_valid,
    input logic        m_ready,
    input logic        req,
    input pend_cnt_t   pend
  );
    gate_state_t nxt;
    nxt = cur;
    case (cur)
      NORMAL:  if (!cap && s_valid && !m_ready) nxt = HOLD;  // handshake started, must finish
               else if (req)                    nxt = DRAIN;
      HOLD:    if (m_ready) nxt = req ? DRAIN : NORMAL;
      DRAIN:   if (pend == '0) nxt = ISOLATE;                // last response is back
      ISOLATE: if (!req) nxt = NORMAL;
      default: nxt = NORMAL;
    endcase
    return nxt;
  endfunction

  // transfers seen on the master side
  assign aw_xfer = m_aw_valid_o & m_aw_ready_i;
  assign w_xfer  = m_w_valid_o  & m_w_ready_i;
  assign b_xfer  = m_b_valid_i  & m_b_ready_o;
  assign ar_xfer = m_ar_valid_o & m_ar_ready_i;
  assign r_xfer  = m_r_valid_i  & m_r_ready_o;

  assign aw_cap = (pend_aw_q == pend_cnt_t'(MAX_PENDING)) ||
                  (w_unlock_q == pend_cnt_t'(MAX_PENDING));  // no room for another data beat
  assign ar_cap = (pend_ar_q == pend_cnt_t'(MAX_PENDING));

  ////////////////////////////////////////
  // counters and state registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pend_aw_q  <= '0;
      pend_ar_q  <= '0;
      w_unlock_q <= '0;
      wr_state_q <= NORMAL;  // ack low out of reset
      rd_state_q <= NORMAL;
    end else begin
      pend_aw_q  <= pend_aw_q + pend_cnt_t'(aw_xfer) - pend_cnt_t'(b_xfer);
      pend_ar_q  <= pend_ar_q + pend_cnt_t'(ar_xfer) - pend_cnt_t'(r_xfer);
      w_unlock_q <= w_unlock_q + pend_cnt_t'(aw_xfer) - pend_cnt_t'(w_xfer);
      wr_state_q <= next_state(wr_state_q, aw_cap, s_aw_valid_i, m_aw_ready_i,
                               iso_req_i, pend_aw_q);
      rd_state_q <= next_state(rd_state_q, ar_cap, s_ar_valid_i, m_ar_ready_i,
                               iso_req_i, pend_ar_q);
    end
  end

  ////////////////////////////////////////
  // write direction, AW and B
  ////////////////////////////////////////

  always_comb begin
    m_aw_valid_o = s_aw_valid_i;  // default is a straight connection
    m_aw_addr_o  = s_aw_addr_i;
    m_aw_id_o    = s_aw_id_i;
    s_aw_ready_o = m_aw_ready_i;
    s_b_valid_o  = m_b_valid_i;
    s_b_id_o     = m_b_id_i;
    m_b_ready_o  = s_b_ready_i;
    case (wr_state_q)
      NORMAL: begin
        if (aw_cap) begin
          m_aw_valid_o = 1'b0;
          s_aw_ready_o = 1'b0;
        end
      end
      HOLD:   m_aw_valid_o = 1'b1;  // ready stays connected
      DRAIN: begin
        m_aw_valid_o = 1'b0;
        m_aw_addr_o  = '0;
        m_aw_id_o    = '0;
        s_aw_ready_o = 1'b0;
      end
      default: begin  // ISOLATE
        m_aw_valid_o = 1'b0;
        m_aw_addr_o  = '0;
        m_aw_id_o    = '0;
        s_aw_ready_o = 1'b0;
        s_b_valid_o  = 1'b0;
        s_b_id_o     = '0;
        m_b_ready_o  = 1'b0;
      end
    endcase
  end

  // w is open once its address went out, or is being offered this cycle
  assign w_open      = (w_unlock_q != '0) | m_aw_valid_o;
  assign m_w_valid_o = s_w_valid_i & w_open;
  assign m_w_data_o  = w_open ? s_w_data_i : '0;
  assign s_w_ready_o = m_w_ready_i & w_open;

  ////////////////////////////////////////
  // read direction, AR and R
  ////////////////////////////////////////

  always_comb begin
    m_ar_valid_o = s_ar_valid_i;
    m_ar_addr_o  = s_ar_addr_i;
    m_ar_id_o    = s_ar_id_i;
    s_ar_ready_o = m_ar_ready_i;
    s_r_valid_o  = m_r_valid_i;
    s_r_id_o     = m_r_id_i;
    s_r_data_o   = m_r_data_i;
    m_r_ready_o  = s_r_ready_i;
    case (rd_state_q)
      NORMAL: begin
        if (ar_cap) begin
          m_ar_valid_o = 1'b0;
          s_ar_ready_o = 1'b0;
        end
      end
      HOLD:   m_ar_valid_o = 1'b1;
      DRAIN: begin
        m_ar_valid_o = 1'b0;
        m_ar_addr_o  = '0;
        m_ar_id_o    = '0;
        s_ar_ready_o = 1'b0;
      end
      default: begin  // ISOLATE
        m_ar_valid_o = 1'b0;
        m_ar_addr_o  = '0;
        m_ar_id_o    = '0;
        s_ar_ready_o = 1'b0;
        s_r_valid_o  = 1'b0;
        s_r_id_o     = '0;
        s_r_data_o   = '0;
        m_r_ready_o  = 1'b0;
      end
    endcase
  end

  // ack straight from the state flops, both directions must be quiet
  assign iso_ack_o = (wr_state_q == ISOLATE) && (rd_state_q == ISOLATE);

endmodule : bus_isolate

`default_nettype wire

//--- resp_fifo.sv
`default_nettype none

module resp_fifo #(
  parameter int unsigned DEPTH = 8,  // power of two keeps the pointer wrap trivial
  parameter int unsigned WIDTH = 8
) (
  input  wire              clk_i,
  input  wire              rst_n_i,
  input  wire              push_i,   // producer strobe, ignored when full
  input  logic [WIDTH-1:0] data_i,
  output logic             full_o,
  input  wire              pop_i,    // consumer ready
  output logic [WIDTH-1:0] data_o,
  output logic             valid_o   // not empty
);

  logic [WIDTH-1:0]         mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr_q, rd_ptr_q;
  logic [$clog2(DEPTH):0]   count_q;  // 0 .. DEPTH
  logic                     do_push, do_pop;

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & valid_o;

  assign full_o  = (count_q == DEPTH);
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];  // head entry, written on an earlier edge

  // control state
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // both or neither
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule : resp_fifo

`default_nettype wire

//--- mem_target.sv
`default_nettype none

module mem_target import bus_pkg::*; (
  input  wire    clk_i,
  input  wire    rst_n_i,
  // write request, address and data taken together
  input  wire    aw_valid_i,
  output logic   aw_ready_o,
  input  addr_t  aw_addr_i,
  input  id_t    aw_id_i,
  input  wire    w_valid_i,
  output logic   w_ready_o,
  input  data_t  w_data_i,
  // read request
  input  wire    ar_valid_i,
  output logic   ar_ready_o,
  input  addr_t  ar_addr_i,
  input  id_t    ar_id_i,
  // write response queue
  output logic   b_push_o,
  output id_t    b_id_o,
  input  wire    b_full_i,
  // read response queue
  output logic   r_push_o,
  output id_t    r_id_o,
  output data_t  r_data_o,
  input  wire    r_full_i
);

  data_t                        mem_q [MEM_WORDS];
  logic [$clog2(MEM_WORDS)-1:0] wr_idx, rd_idx;  // word index from low address bits
  logic                         wr_en, rd_en;

  assign wr_idx = aw_addr_i[$clog2(MEM_WORDS)-1:0];
  assign rd_idx = ar_addr_i[$clog2(MEM_WORDS)-1:0];

  ////////////////////////////////////////
  // acceptance
  ////////////////////////////////////////

  // a write needs both halves and a free B slot
  assign wr_en      = aw_valid_i & w_valid_i & ~b_full_i;
  assign aw_ready_o = wr_en;
  assign w_ready_o  = wr_en;

  assign rd_en      = ar_valid_i & ~r_full_i;
  assign ar_ready_o = rd_en;

  ////////////////////////////////////////
  // responses
  ////////////////////////////////////////

  assign b_push_o = wr_en;     // queued on the accepting edge
  assign b_id_o   = aw_id_i;

  assign r_push_o = rd_en;
  assign r_id_o   = ar_id_i;
  assign r_data_o = mem_q[rd_idx];  // old word if a write hits the same cycle

  // array, starts from zero
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_en) begin
      mem_q[wr_idx] <= w_data_i;
    end
  end

endmodule : mem_target

`default_nettype wire

//--- isolated_mem.sv
`default_nettype none

module isolated_mem import bus_pkg::*; (
  input  wire    clk_i,
  input  wire    rst_n_i,
  input  wire    s_aw_valid_i,
  output wire    s_aw_ready_o,
  input  addr_t  s_aw_addr_i,
  input  id_t    s_aw_id_i,
  input  wire    s_w_valid_i,
  output wire    s_w_ready_o,
  input  data_t  s_w_data_i,
  output wire    s_b_valid_o,
  input  wire    s_b_ready_i,
  output id_t    s_b_id_o,
  input  wire    s_ar_valid_i,
  output wire    s_ar_ready_o,
  input  addr_t  s_ar_addr_i,
  input  id_t    s_ar_id_i,
  output wire    s_r_valid_o,
  input  wire    s_r_ready_i,
  output id_t    s_r_id_o,
  output data_t  s_r_data_o,
  input  wire    iso_req_i,   // from the power manager
  output wire    iso_ack_o
);

  // gate to target and queues
  wire        m_aw_valid, m_aw_ready, m_w_valid, m_w_ready, m_ar_valid, m_ar_ready;
  wire addr_t m_aw_addr, m_ar_addr;
  wire id_t   m_aw_id, m_ar_id;
  wire data_t m_w_data;
  wire        m_b_valid, m_b_ready, m_r_valid, m_r_ready;  // queue heads
  wire id_t   m_b_id, m_r_id;
  wire data_t m_r_data;
  // target to queues
  wire        b_push, b_full, r_push, r_full;
  wire id_t   b_push_id, r_push_id;
  wire data_t r_push_data;

  bus_isolate u_gate (
    .clk_i, .rst_n_i,
    .s_aw_valid_i, .s_aw_ready_o, .s_aw_addr_i, .s_aw_id_i,
    .s_w_valid_i,  .s_w_ready_o,  .s_w_data_i,
    .s_b_valid_o,  .s_b_ready_i,  .s_b_id_o,
    .s_ar_valid_i, .s_ar_ready_o, .s_ar_addr_i, .s_ar_id_i,
    .s_r_valid_o,  .s_r_ready_i,  .s_r_id_o,    .s_r_data_o,
    .m_aw_valid_o (m_aw_valid), .m_aw_ready_i (m_aw_ready),
    .m_aw_addr_o  (m_aw_addr),  .m_aw_id_o    (m_aw_id),
    .m_w_valid_o  (m_w_valid),  .m_w_ready_i  (m_w_ready),  .m_w_data_o (m_w_data),
    .m_b_valid_i  (m_b_valid),  .m_b_ready_o  (m_b_ready),  .m_b_id_i   (m_b_id),
    .m_ar_valid_o (m_ar_valid), .m_ar_ready_i (m_ar_ready),
    .m_ar_addr_o  (m_ar_addr),  .m_ar_id_o    (m_ar_id),
    .m_r_valid_i  (m_r_valid),  .m_r_ready_o  (m_r_ready),
    .m_r_id_i     (m_r_id),     .m_r_data_i   (m_r_data),
    .iso_req_i, .iso_ack_o
  );

  mem_target u_target (
    .clk_i, .rst_n_i,
    .aw_valid_i (m_aw_valid), .aw_ready_o (m_aw_ready),
    .aw_addr_i  (m_aw_addr),  .aw_id_i    (m_aw_id),
    .w_valid_i  (m_w_valid),  .w_ready_o  (m_w_ready),  .w_data_i (m_w_data),
    .ar_valid_i (m_ar_valid), .ar_ready_o (m_ar_ready),
    .ar_addr_i  (m_ar_addr),  .ar_id_i    (m_ar_id),
    .b_push_o   (b_push),     .b_id_o     (b_push_id),  .b_full_i (b_full),
    .r_push_o   (r_push),     .r_id_o     (r_push_id),
    .r_data_o   (r_push_data), .r_full_i  (r_full)
  );

  // deeper than the gate cap, never the limiting factor
  resp_fifo #(.DEPTH(8), .WIDTH(ID_W)) b_fifo (
    .clk_i, .rst_n_i,
    .push_i (b_push),    .data_i  (b_push_id), .full_o (b_full),
    .pop_i  (m_b_ready), .data_o  (m_b_id),    .valid_o (m_b_valid)
  );

  resp_fifo #(.DEPTH(8), .WIDTH(ID_W + DATA_W)) r_fifo (
    .clk_i, .rst_n_i,
    .push_i (r_push),    .data_i  ({r_push_id, r_push_data}), .full_o (r_full),
    .pop_i  (m_r_ready), .data_o  ({m_r_id, m_r_data}),       .valid_o (m_r_valid)
  );

endmodule : isolated_mem

`default_nettype wire

//--- tb_isolated_mem.sv
`default_nettype none

module tb_isolated_mem import bus_pkg::*; import iso_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned TIMEOUT_CYCLES = 6000;  // ~20 cycles per transaction plus margin
  localparam int unsigned DRAIN_LIMIT    = 200;   // cycles allowed for responses to come back

  logic  clk_i, rst_n_i;
  logic  s_aw_valid_i, s_aw_ready_o, s_w_valid_i, s_w_ready_o;
  addr_t s_aw_addr_i, s_ar_addr_i;
  id_t   s_aw_id_i, s_ar_id_i, s_b_id_o, s_r_id_o;
  data_t s_w_data_i, s_r_data_o;
  logic  s_b_valid_o, s_b_ready_i, s_ar_valid_i, s_ar_ready_o, s_r_valid_o, s_r_ready_i;
  logic  iso_req_i, iso_ack_o;

  // ready control for the response channels
  logic        hold_b, hold_r, rand_ready;
  logic [31:0] stim_seed, rdy_seed;  // separate streams for requests and readies

  // reference model
  data_t ref_mem [MEM_WORDS];
  id_t   exp_b_q [$];       // expected B ids, request order
  id_t   exp_r_id_q [$];
  data_t exp_r_data_q [$];
  int    aw_count;          // AW transfers seen on the slave port
  int    cycle_cnt;

  isolated_mem dut (.*);

  always #5 clk_i = ~clk_i;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // word the memory should return, low address bits select the entry
  function automatic data_t ref_read(input addr_t a);
    return ref_mem[a % MEM_WORDS];
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_id(input string name, input id_t exp, input id_t act);
    if (act !== exp)
      stop_with_error($sformatf("Mismatch at %0t: %s expected %h actual %h",
                                $time, name, exp, act));
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp)
      stop_with_error($sformatf("Mismatch at %0t: %s expected %h actual %h",
                                $time, name, exp, act));
  endtask

  task automatic check_ack(input string name, input logic exp, input logic act);
    if (act !== exp)
      stop_with_error($sformatf("Mismatch at %0t: %s expected %b actual %b",
                                $time, name, exp, act));
  endtask

  ////////////////////////////////////////
  // master driver, called on a falling edge, returns on one
  ////////////////////////////////////////

  task automatic start_write(input addr_t a, input id_t id, input data_t d);
    s_aw_valid_i = 1'b1;  // AW and W offered together
    s_aw_addr_i  = a;
    s_aw_id_i    = id;
    s_w_valid_i  = 1'b1;
    s_w_data_i   = d;
  endtask

  task automatic finish_write();
    do @(posedge clk_i); while (!s_aw_ready_o);  // payload held until taken
    @(negedge clk_i);
    s_aw_valid_i = 1'b0;
    s_w_valid_i  = 1'b0;
  endtask

  task automatic do_write(input addr_t a, input id_t id, input data_t d);
    start_write(a, id, d);
    finish_write();
  endtask

  task automatic start_read(input addr_t a, input id_t id);
    s_ar_valid_i = 1'b1;
    s_ar_addr_i  = a;
    s_ar_id_i    = id;
  endtask

  task automatic do_read(input addr_t a, input id_t id);
    start_read(a, id);
    do @(posedge clk_i); while (!s_ar_ready_o);
    @(negedge clk_i);
    s_ar_valid_i = 1'b0;
  endtask

  // a write and a read offered together, each dropped once its own ready was seen
  task automatic finish_write_and_read();
    logic aw_done, ar_done;
    aw_done = 1'b0;
    ar_done = 1'b0;
    while (!(aw_done && ar_done)) begin
      @(posedge clk_i);
      aw_done = aw_done | s_aw_ready_o;
      ar_done = ar_done | s_ar_ready_o;
      @(negedge clk_i);
      if (aw_done) begin
        s_aw_valid_i = 1'b0;
        s_w_valid_i  = 1'b0;
      end
      if (ar_done) s_ar_valid_i = 1'b0;
    end
  endtask

  // wait until every request has been answered
  task automatic wait_drained();
    int n;
    n = 0;
    @(negedge clk_i);
    while (exp_b_q.size() != 0 || exp_r_id_q.size() != 0) begin
      if (n == DRAIN_LIMIT) stop_with_error("responses still outstanding after the drain limit");
      @(negedge clk_i);
      n++;
    end
  endtask

  task automatic run_random(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      stim_seed = xorshift32(stim_seed);
      r = stim_seed;
      stim_seed = xorshift32(stim_seed);
      if (r[31]) do_write(r[7:0], r[11:8], stim_seed);
      else       do_read(r[7:0], r[11:8]);
    end
  endtask

  ////////////////////////////////////////
  // response readies, driven on the falling edge
  ////////////////////////////////////////

  always @(negedge clk_i) begin
    rdy_seed    = xorshift32(rdy_seed);
    s_b_ready_i = hold_b ? 1'b0 : (rand_ready ? rdy_seed[7] : 1'b1);
    s_r_ready_i = hold_r ? 1'b0 : (rand_ready ? rdy_seed[19] : 1'b1);
  end

  ////////////////////////////////////////
  // compare process
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (iso_ack_o) begin  // isolated, nothing may move
        if (exp_b_q.size() != 0 || exp_r_id_q.size() != 0)
          stop_with_error("isolation acknowledged while responses were still outstanding");
        check_ack("s_aw_ready_o", 1'b0, s_aw_ready_o);
        check_ack("s_ar_ready_o", 1'b0, s_ar_ready_o);
        check_ack("s_b_valid_o", 1'b0, s_b_valid_o);
        check_ack("s_r_valid_o", 1'b0, s_r_valid_o);
      end
      // read sampled before the write so a same-edge hit sees the old word
      if (s_ar_valid_i && s_ar_ready_o) begin
        exp_r_id_q.push_back(s_ar_id_i);
        exp_r_data_q.push_back(ref_read(s_ar_addr_i));
      end
      if ((s_aw_valid_i && s_aw_ready_o) != (s_w_valid_i && s_w_ready_o))
        stop_with_error("write address and data beat were not accepted together");
      if (s_aw_valid_i && s_aw_ready_o) begin
        ref_mem[s_aw_addr_i % MEM_WORDS] = s_w_data_i;
        exp_b_q.push_back(s_aw_id_i);
        aw_count++;
      end
      if (s_b_valid_o && s_b_ready_i) begin
        if (exp_b_q.size() == 0) stop_with_error("write response with no write outstanding");
        check_id("s_b_id_o", exp_b_q.pop_front(), s_b_id_o);
      end
      if (s_r_valid_o && s_r_ready_i) begin
        if (exp_r_id_q.size() == 0) stop_with_error("read response with no read outstanding");
        check_id("s_r_id_o", exp_r_id_q.pop_front(), s_r_id_o);
        check_data("s_r_data_o", exp_r_data_q.pop_front(), s_r_data_o);
      end
    end
  end

  // hang guard
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      stop_with_error($sformatf("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES));
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    int aw_base;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    s_aw_valid_i = 1'b0;
    s_aw_addr_i = '0;
    s_aw_id_i = '0;
    s_w_valid_i = 1'b0;
    s_w_data_i = '0;
    s_b_ready_i = 1'b0;
    s_ar_valid_i = 1'b0;
    s_ar_addr_i = '0;
    s_ar_id_i = '0;
    s_r_ready_i = 1'b0;
    iso_req_i = 1'b0;
    hold_b = 1'b0;
    hold_r = 1'b0;
    rand_ready = 1'b0;
    stim_seed = 32'd26;
    rdy_seed = xorshift32(32'd26);
    aw_count = 0;
    cycle_cnt = 0;
    foreach (ref_mem[i]) ref_mem[i] = '0;  // target clears its array at reset

    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(posedge clk_i);
    check_ack("s_b_valid_o", 1'b0, s_b_valid_o);
    check_ack("s_r_valid_o", 1'b0, s_r_valid_o);
    check_ack("iso_ack_o", 1'b0, iso_ack_o);
    @(negedge clk_i);

    // directed writes, then reads of the same words
    for (int i = 0; i < 8; i++) do_write(addr_t'(i), id_t'(i), 32'hc0de_0000 + i * 32'h111);
    for (int i = 0; i < 8; i++) do_read(addr_t'(i), id_t'(15 - i));
    wait_drained();

    // random traffic with back-pressure on B and R
    rand_ready = 1'b1;
    run_random(200);
    rand_ready = 1'b0;
    wait_drained();

    // write cap with B held off
    hold_b = 1'b1;
    @(negedge clk_i);
    aw_base = aw_count;
    for (int i = 0; i < MAX_PENDING; i++) do_write(addr_t'(8 + i), id_t'(i), 32'hcafe_0000 + i);
    start_write(8'h0c, 4'h9, 32'hcafe_00ff);
    repeat (10) begin
      @(posedge clk_i);
      check_ack("s_aw_ready_o", 1'b0, s_aw_ready_o);
    end
    if (aw_count - aw_base != int'(MAX_PENDING))
      stop_with_error("write count with B held off differs from the pending cap");
    @(negedge clk_i);
    hold_b = 1'b0;  // responses drain, the blocked write goes through
    finish_write();
    wait_drained();

    // isolation request with responses outstanding
    hold_b = 1'b1;
    hold_r = 1'b1;
    @(negedge clk_i);
    do_write(8'h02, 4'h3, 32'h1234_5678);
    do_write(8'h05, 4'h4, 32'h9abc_def0);
    do_read(8'h02, 4'h5);
    do_read(8'h07, 4'h6);
    iso_req_i = 1'b1;
    repeat (8) begin
      @(posedge clk_i);
      check_ack("iso_ack_o", 1'b0, iso_ack_o);  // four responses still queued
    end
    @(negedge clk_i);
    hold_b = 1'b0;
    hold_r = 1'b0;
    do @(posedge clk_i); while (!iso_ack_o);
    @(negedge clk_i);
    start_write(8'h0e, 4'ha, 32'h5555_aaaa);  // both must stay blocked while isolated
    start_read(8'h05, 4'hb);
    repeat (6) @(posedge clk_i);
    @(negedge clk_i);
    iso_req_i = 1'b0;
    finish_write_and_read();
    check_ack("iso_ack_o", 1'b0, iso_ack_o);  // both directions back in service

    // earlier data survives isolation
    for (int i = 0; i < MEM_WORDS; i++) do_read(addr_t'(i), id_t'(i));
    wait_drained();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule : tb_isolated_mem

`default_nettype wire

//--- flist.f
bus_pkg.sv
iso_pkg.sv
bus_isolate.sv
resp_fifo.sv
mem_target.sv
isolated_mem.sv
tb_isolated_mem.sv
